// File: verilog/stream_pkg.sv
package stream_pkg;

    // ------------------------------
    // Data widths
    // ------------------------------

    // Incoming byte lane
    localparam int BYTE_W = 8;

    // Stored and presented word, two bytes per entry
    localparam int WORD_W = 16;

    // ------------------------------
    // FIFO geometry
    // ------------------------------

    // Must stay a power of two
    localparam int FIFO_DEPTH = 8;
    localparam int ADDR_W = 3;

    // One extra bit so a full buffer can be told from an empty one
    localparam int LEVEL_W = ADDR_W + 1;

    // Flag thresholds on occupancy, both inclusive
    localparam int AFULL_LEVEL = 6;
    localparam int AEMPTY_LEVEL = 2;

    // Dropped word counter, sticks at all ones
    localparam int DROP_W = 8;

    // ------------------------------
    // FIFO entry
    // ------------------------------

    // One packed word plus its frame-end marker
    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              last;
    } word_entry_t;

endpackage

// File: verilog/byte_packer.sv
`timescale 1ns/100ps

module byte_packer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  logic [stream_pkg::BYTE_W-1:0]  in_data,
    input  logic                           in_last,
    output logic                           push,
    output stream_pkg::word_entry_t        push_entry
);

    // Upper byte held while waiting for its partner
    logic [stream_pkg::BYTE_W-1:0] hi_byte;

    // High while hi_byte holds a pending upper byte
    logic phase;

    // ------------------------------
    // Pair tracking
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= 1'b0;
        end else if (in_valid) begin
            // A frame end always closes the word, so the next frame
            // begins on an upper byte
            if (phase || in_last) begin
                phase <= 1'b0;
            end else begin
                phase <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !phase) begin
            hi_byte <= in_data;
        end
    end

    // ------------------------------
    // Word output
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= in_valid && (phase || in_last);
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            if (phase) begin
                // Second byte completes the pair
                push_entry.data <= {hi_byte, in_data};
                push_entry.last <= in_last;
            end else if (in_last) begin
                // Odd final byte, lower half padded with zero
                push_entry.data <= {in_data, {stream_pkg::BYTE_W{1'b0}}};
                push_entry.last <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
    parameter int DEPTH = stream_pkg::FIFO_DEPTH,
    parameter int AW = stream_pkg::ADDR_W
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           push,
    input  stream_pkg::word_entry_t        push_entry,
    input  logic                           pop,
    output stream_pkg::word_entry_t        rd_entry,
    output logic                           rd_valid,
    output logic [stream_pkg::LEVEL_W-1:0] level,
    output logic                           full,
    output logic                           empty,
    output logic                           almost_full,
    output logic                           almost_empty,
    output logic                           overflow,
    output logic [stream_pkg::DROP_W-1:0]  drop_count
);

    stream_pkg::word_entry_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    // Accepted operations only
    logic wr_ok;
    logic rd_ok;

    assign wr_ok = push && !full;
    assign rd_ok = pop && !empty;

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_ok) begin
            if (wr_ptr == AW'(DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_ok) begin
            if (rd_ptr == AW'(DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Write and read together leave the count alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (wr_ok && !rd_ok) begin
            count <= count + 1'b1;
        end else if (rd_ok && !wr_ok) begin
            count <= count - 1'b1;
        end
    end

    assign level        = stream_pkg::LEVEL_W'(count);
    assign full         = (count == (AW + 1)'(DEPTH));
    assign empty        = (count == '0);
    assign almost_full  = (count >= (AW + 1)'(stream_pkg::AFULL_LEVEL));
    assign almost_empty = (count <= (AW + 1)'(stream_pkg::AEMPTY_LEVEL));

    // ------------------------------
    // Storage and registered read
    // ------------------------------

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= push_entry;
        end
        if (rd_ok) begin
            rd_entry <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_ok;
        end
    end

    // ------------------------------
    // Drop accounting
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow   <= 1'b0;
            drop_count <= '0;
        end else begin
            overflow <= push && full;
            if (push && full && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

endmodule

// File: verilog/frame_drain.sv
`timescale 1ns/100ps

module frame_drain (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          out_ready,
    output logic                          pop,
    input  stream_pkg::word_entry_t       rd_entry,
    input  logic                          rd_valid,
    output logic                          out_valid,
    output logic [stream_pkg::WORD_W-1:0] out_data,
    output logic                          out_last,
    output logic                          frame_done,
    output logic [stream_pkg::WORD_W-1:0] frame_sum
);

    // Running sum of the words seen so far in this frame
    logic [stream_pkg::WORD_W-1:0] acc;

    // Sum including the word now on the output
    logic [stream_pkg::WORD_W-1:0] acc_next;

    // ------------------------------
    // Sink side
    // ------------------------------

    // Ready is a level, so keep requesting while it holds
    assign pop = out_ready;

    assign out_valid = rd_valid;
    assign out_data  = rd_entry.data;
    assign out_last  = rd_entry.last;

    // ------------------------------
    // Checksum
    // ------------------------------

    // Wraps modulo 2^16
    assign acc_next = acc + rd_entry.data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (rd_valid) begin
            if (rd_entry.last) begin
                acc <= '0;
            end else begin
                acc <= acc_next;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_done <= 1'b0;
            frame_sum  <= '0;
        end else begin
            frame_done <= rd_valid && rd_entry.last;
            // Hold the last total until the next frame closes
            if (rd_valid && rd_entry.last) begin
                frame_sum <= acc_next;
            end
        end
    end

endmodule

// File: verilog/stream_buffer_top.sv
`timescale 1ns/100ps

module stream_buffer_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  logic [stream_pkg::BYTE_W-1:0]  in_data,
    input  logic                           in_last,
    input  logic                           out_ready,
    output logic                           out_valid,
    output logic [stream_pkg::WORD_W-1:0]  out_data,
    output logic                           out_last,
    output logic                           frame_done,
    output logic [stream_pkg::WORD_W-1:0]  frame_sum,
    output logic [stream_pkg::LEVEL_W-1:0] level,
    output logic                           full,
    output logic                           empty,
    output logic                           almost_full,
    output logic                           almost_empty,
    output logic                           overflow,
    output logic [stream_pkg::DROP_W-1:0]  drop_count
);

    // Packer to FIFO
    logic                    push;
    stream_pkg::word_entry_t push_entry;

    // FIFO to drain
    logic                    pop;
    stream_pkg::word_entry_t rd_entry;
    logic                    rd_valid;

    byte_packer u_packer (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_last    (in_last),
        .push       (push),
        .push_entry (push_entry)
    );

    sync_fifo #(
        .DEPTH (stream_pkg::FIFO_DEPTH),
        .AW    (stream_pkg::ADDR_W)
    ) u_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .push         (push),
        .push_entry   (push_entry),
        .pop          (pop),
        .rd_entry     (rd_entry),
        .rd_valid     (rd_valid),
        .level        (level),
        .full         (full),
        .empty        (empty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .overflow     (overflow),
        .drop_count   (drop_count)
    );

    frame_drain u_drain (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_ready  (out_ready),
        .pop        (pop),
        .rd_entry   (rd_entry),
        .rd_valid   (rd_valid),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .frame_done (frame_done),
        .frame_sum  (frame_sum)
    );

endmodule

// File: testbench/tb_stream_buffer.sv
`timescale 1ns/100ps

module tb_stream_buffer;

    typedef logic [7:0] byte_q_t[$];
    typedef stream_pkg::word_entry_t entry_q_t[$];

    localparam int TIMEOUT = 1000;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [7:0]  in_data;
    logic        in_last;
    logic        out_ready;
    logic        out_valid;
    logic [15:0] out_data;
    logic        out_last;
    logic        frame_done;
    logic [15:0] frame_sum;
    logic [3:0]  level;
    logic        full;
    logic        empty;
    logic        almost_full;
    logic        almost_empty;
    logic        overflow;
    logic [7:0]  drop_count;

    // Scoreboard
    entry_q_t                exp_q;
    logic [15:0]             sum_q[$];
    stream_pkg::word_entry_t exp_word;
    logic [15:0]             exp_sum;

    logic [31:0] lfsr = 32'h2cce;
    logic        rand_ready = 1'b0;
    logic        track_levels = 1'b0;
    logic [8:0]  levels_seen = '0;
    int          overflow_pulses = 0;
    int          mon_errors = 0;
    int          tb_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors_at_start = 0;
    string       test_name;

    stream_buffer_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    // Byte pairs, first byte high, odd tail padded with zero
    function automatic logic [15:0] pack_frame(input byte_q_t bytes, output entry_q_t words);
        stream_pkg::word_entry_t w;
        logic [15:0] sum;
        int n;
        n = bytes.size();
        sum = '0;
        words = {};
        for (int i = 0; i < n; i += 2) begin
            w.data[15:8] = bytes[i];
            w.data[7:0] = (i + 1 < n) ? bytes[i + 1] : 8'h00;
            w.last = (i + 2 >= n);
            words.push_back(w);
            sum = sum + w.data;
        end
        return sum;
    endfunction

    task automatic step();
        @(posedge clk);
        if (rand_ready) begin
            out_ready <= rand_bit();
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            tb_errors++;
        end
    endtask

    task automatic apply_reset();
        step();
        rst_n <= 1'b0;
        in_valid <= 1'b0;
        in_last <= 1'b0;
        repeat (5) step();
        rst_n <= 1'b1;
    endtask

    // Hold off the next byte until the FIFO has room for it
    task automatic wait_room();
        int t;
        t = 0;
        @(negedge clk);
        while (level > 4'd5 && t < TIMEOUT) begin
            step();
            in_valid <= 1'b0;
            in_last <= 1'b0;
            @(negedge clk);
            t++;
        end
        if (level > 4'd5) begin
            $display("Timeout while waiting for room in the FIFO");
            tb_errors++;
        end
    endtask

    task automatic drive_bytes(input byte_q_t bytes, input bit throttle);
        int i;
        for (i = 0; i < bytes.size(); i++) begin
            if (throttle) begin
                wait_room();
            end
            step();
            in_valid <= 1'b1;
            in_data <= bytes[i];
            in_last <= (i == bytes.size() - 1);
        end
        step();
        in_valid <= 1'b0;
        in_last <= 1'b0;
    endtask

    task automatic expect_frame(input byte_q_t bytes);
        entry_q_t words;
        logic [15:0] sum;
        sum = pack_frame(bytes, words);
        foreach (words[i]) begin
            exp_q.push_back(words[i]);
        end
        sum_q.push_back(sum);
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        @(negedge clk);
        while ((exp_q.size() != 0 || sum_q.size() != 0) && t < TIMEOUT) begin
            step();
            @(negedge clk);
            t++;
        end
        if (t == TIMEOUT) begin
            $display("Timeout: %0d words still expected at the output", exp_q.size());
            tb_errors++;
        end
    endtask

    // Last packed word lands in the FIFO two edges after its final byte
    task automatic settle_packer();
        repeat (2) step();
        @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = tb_errors + mon_errors;
        tests_run++;
    endtask

    task automatic end_test();
        int delta;
        delta = tb_errors + mon_errors - errors_at_start;
        if (delta == 0) begin
            $display("Test %0d %s: ok", tests_run, test_name);
        end else begin
            $display("Test %0d %s: FAILED with %0d errors", tests_run, test_name, delta);
            tests_failed++;
        end
    endtask

    // ------------------------------
    // Output checker
    // ------------------------------

    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected word %h on the output", out_data);
                    mon_errors++;
                end else begin
                    exp_word = exp_q.pop_front();
                    assert (out_data == exp_word.data) else begin
                        $display("Mismatch out_data: got %h, expected %h",
                                 out_data, exp_word.data);
                        mon_errors++;
                    end
                    assert (out_last == exp_word.last) else begin
                        $display("Mismatch out_last: got %h, expected %h",
                                 out_last, exp_word.last);
                        mon_errors++;
                    end
                end
            end
            if (frame_done) begin
                if (sum_q.size() == 0) begin
                    $display("Frame end reported with no frame outstanding");
                    mon_errors++;
                end else begin
                    exp_sum = sum_q.pop_front();
                    assert (frame_sum == exp_sum) else begin
                        $display("Mismatch frame_sum: got %h, expected %h", frame_sum, exp_sum);
                        mon_errors++;
                    end
                end
            end
            assert (almost_empty == (32'(level) <= stream_pkg::AEMPTY_LEVEL)) else begin
                $display("Mismatch almost_empty: got %h at level %h", almost_empty, level);
                mon_errors++;
            end
            assert (almost_full == (32'(level) >= stream_pkg::AFULL_LEVEL)) else begin
                $display("Mismatch almost_full: got %h at level %h", almost_full, level);
                mon_errors++;
            end
            if (overflow) begin
                overflow_pulses++;
            end
            if (track_levels) begin
                levels_seen[level] = 1'b1;
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        byte_q_t bytes;
        int drops_before;
        int len;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_last = 1'b0;
        out_ready = 1'b0;
        apply_reset();

        begin_test("reset values");
        @(negedge clk);
        check_value("empty", 32'(empty), 1);
        check_value("almost_empty", 32'(almost_empty), 1);
        check_value("full", 32'(full), 0);
        check_value("almost_full", 32'(almost_full), 0);
        check_value("out_valid", 32'(out_valid), 0);
        check_value("frame_done", 32'(frame_done), 0);
        check_value("level", 32'(level), 0);
        check_value("drop_count", 32'(drop_count), 0);
        end_test();

        begin_test("even frame");
        step();
        out_ready <= 1'b1;
        bytes = {8'h12, 8'h34, 8'hab, 8'hcd, 8'hf0, 8'h0f};
        expect_frame(bytes);
        drive_bytes(bytes, 1'b0);
        wait_drained();
        end_test();

        begin_test("odd frame");
        bytes = {8'h81, 8'h7e, 8'hff, 8'hee, 8'h5a};
        expect_frame(bytes);
        drive_bytes(bytes, 1'b0);
        wait_drained();
        end_test();

        begin_test("overflow");
        step();
        out_ready <= 1'b0;
        drops_before = overflow_pulses;
        // Single-word frames, only the first eight fit
        for (int w = 0; w < 12; w++) begin
            bytes = {8'(8'h30 + w), 8'(8'hc0 ^ w)};
            if (w < 8) begin
                expect_frame(bytes);
            end
            drive_bytes(bytes, 1'b0);
        end
        settle_packer();
        check_value("level", 32'(level), 8);
        check_value("full", 32'(full), 1);
        check_value("almost_full", 32'(almost_full), 1);
        check_value("drop_count", 32'(drop_count), 4);
        check_value("overflow pulses", 32'(overflow_pulses - drops_before), 4);
        step();
        out_ready <= 1'b1;
        wait_drained();
        check_value("empty", 32'(empty), 1);
        end_test();

        begin_test("thresholds");
        track_levels = 1'b1;
        step();
        out_ready <= 1'b0;
        for (int w = 0; w < 8; w++) begin
            bytes = {8'(w * 8'h11), 8'(8'h5a + w)};
            expect_frame(bytes);
            drive_bytes(bytes, 1'b0);
            repeat (2) step();
        end
        step();
        out_ready <= 1'b1;
        wait_drained();
        track_levels = 1'b0;
        check_value("levels seen", 32'(levels_seen), 32'h1ff);
        end_test();

        begin_test("random frames");
        apply_reset();
        rand_ready = 1'b1;
        for (int f = 0; f < 20; f++) begin
            len = int'(rand_bits(4) % 9) + 1;
            bytes = {};
            for (int i = 0; i < len; i++) begin
                bytes.push_back(8'(rand_bits(8)));
            end
            expect_frame(bytes);
            drive_bytes(bytes, 1'b1);
        end
        wait_drained();
        rand_ready = 1'b0;
        check_value("drop_count", 32'(drop_count), 0);
        end_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 tb_errors + mon_errors);
        if (tests_failed == 0 && tb_errors + mon_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sources.f
verilog/stream_pkg.sv
verilog/byte_packer.sv
verilog/sync_fifo.sv
verilog/frame_drain.sv
verilog/stream_buffer_top.sv
testbench/tb_stream_buffer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the stream buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_stream_buffer \
    -o sim_stream_buffer

./obj_dir/sim_stream_buffer > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi

echo "Pass message not found in sim.log"
exit 1
